// ==== wb_cdb.f ====
src/cdb_pkg.sv
src/op_dispatcher.sv
src/alu_unit.sv
src/iter_mul_unit.sv
src/prio_2way_arbiter.sv
src/wb_cdb_top.sv
dv/tb_wb_cdb.sv

// ==== Makefile ====
# Verilator simulation of the write-back CDB stage

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_wb_cdb
FILELIST  = wb_cdb.f

OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_wb_cdb.sv ====
// ------------------------------------------------
// Write-back CDB testbench
// ------------------------------------------------

`timescale 1ns/1ps

module tb_wb_cdb;
    import cdb_pkg::*;

    // ------------------------------------------------
    // Run length
    // ------------------------------------------------

    localparam int unsigned N_ALU      = 100;
    localparam int unsigned N_MUL      = 40;
    localparam int unsigned N_MIX      = 100;
    localparam int unsigned N_BP       = 100;
    localparam int unsigned N_PRE_RST  = 20;
    localparam int unsigned N_POST_RST = 40;
    localparam int unsigned NUM_OPS    = N_ALU + N_MUL + N_MIX + N_BP + N_PRE_RST + N_POST_RST;
    // A MUL round trip with stalls stays well inside 40 cycles
    localparam int unsigned MAX_CYCLES = NUM_OPS * 40;

    // Longest drain, one MUL plus stalled ALU results
    localparam int unsigned DRAIN_LIMIT = 200;

    // Operation mix of a stream
    localparam int MODE_ALU = 0;
    localparam int MODE_MUL = 1;
    localparam int MODE_MIX = 2;

    // DUT ports
    logic        clk_i;
    logic        arst_n_i;
    logic        req_valid_i;
    op_req_t     req_i;
    logic        req_ready_o;
    logic        cdb_valid_o;
    cdb_pkt_t    cdb_o;
    logic        cdb_ready_i;

    // Scoreboard, one slot per tag
    xlen_t       exp_val [32];
    logic        pending [32];
    logic        is_alu  [32];
    tag_t        alu_order [$];
    int unsigned pend_cnt;
    tag_t        next_tag;

    // Request went in at the last edge
    logic        req_taken;

    logic [31:0] rng_state;
    int unsigned issued;
    int unsigned errors;
    int unsigned fails;
    int unsigned cycles = 0;

    wb_cdb_top wb_cdb_top_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .cdb_valid_o (cdb_valid_o),
        .cdb_o       (cdb_o),
        .cdb_ready_i (cdb_ready_i)
    );

    // 40 ns period
    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
    end

    // ------------------------------------------------
    // Random numbers and reference model
    // ------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Expected result straight from the operation rules
    function automatic xlen_t model_result(input op_req_t r);
        case (r.op)
            ADD:     return r.rs1 + r.rs2;
            SUB:     return r.rs1 - r.rs2;
            AND:     return r.rs1 & r.rs2;
            OR:      return r.rs1 | r.rs2;
            XOR:     return r.rs1 ^ r.rs2;
            SLL:     return r.rs1 << r.rs2[4:0];
            SRL:     return r.rs1 >> r.rs2[4:0];
            // Low half of the product
            MUL:     return r.rs1 * r.rs2;
            default: return '0;
        endcase
    endfunction

    // Edge operands mixed in with plain random ones
    task automatic pick_operand(output xlen_t v);
        logic [31:0] sel;
        sel = rand32();
        case (sel[2:0])
            3'd0:    v = '0;
            3'd1:    v = '1;
            3'd2:    v = 32'h8000_0000;
            default: v = rand32();
        endcase
    endtask

    task automatic make_request(input int mode, output op_req_t r);
        logic [31:0] sel;
        logic [2:0]  code;
        xlen_t       a;
        xlen_t       b;
        sel  = rand32();
        code = 3'(sel % 32'd7);
        // About one MUL in eight for mixed streams
        if (mode == MODE_MUL || (mode == MODE_MIX && sel[10:8] == 3'd0)) begin
            r.op = MUL;
        end else begin
            r.op = fu_op_e'(code);
        end
        pick_operand(a);
        pick_operand(b);
        r.rs1 = a;
        r.rs2 = b;
        r.tag = next_tag;
    endtask

    // ------------------------------------------------
    // Checking
    // ------------------------------------------------

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Handshakes that complete at the coming rising edge
    task automatic observe_handshakes();
        if (req_valid_i && req_ready_o) begin
            exp_val[req_i.tag] = model_result(req_i);
            pending[req_i.tag] = 1'b1;
            is_alu[req_i.tag]  = (req_i.op != MUL);
            if (req_i.op != MUL) begin
                alu_order.push_back(req_i.tag);
            end
            pend_cnt++;
            issued++;
            next_tag  = next_tag + 5'd1;
            req_taken = 1'b1;
        end
        if (cdb_valid_o && cdb_ready_i) begin
            if (!pending[cdb_o.tag]) begin
                fails++;
                $display("Unexpected result at %0t ns: tag %0d has no operation pending",
                         $time, cdb_o.tag);
            end else begin
                check_equal(cdb_o.value, exp_val[cdb_o.tag],
                            $sformatf("CDB value for tag %0d", cdb_o.tag));
                // In-order ALU results leave in issue order
                if (is_alu[cdb_o.tag]) begin
                    check_equal(32'(cdb_o.tag), 32'(alu_order[0]), "ALU result order");
                    void'(alu_order.pop_front());
                end
                pending[cdb_o.tag] = 1'b0;
                pend_cnt--;
            end
        end
    endtask

    // ------------------------------------------------
    // Stimulus
    // ------------------------------------------------

    task automatic run_cycle(input logic allow_new, input int mode, input int unsigned bp_pct);
        logic [31:0] r;
        @(negedge clk_i);
        if (req_taken) begin
            req_valid_i = 1'b0;
            req_taken   = 1'b0;
        end
        r = rand32();
        // Idle gaps, and a tag waits until its slot is free
        if (allow_new && !req_valid_i && !pending[next_tag] && r[1:0] != 2'd0) begin
            make_request(mode, req_i);
            req_valid_i = 1'b1;
        end
        cdb_ready_i = (rand32() % 32'd100) >= bp_pct;
        // Let the combinational paths settle
        #1;
        observe_handshakes();
    endtask

    task automatic run_ops(input int unsigned n, input int mode, input int unsigned bp_pct);
        int unsigned target;
        target = issued + n;
        while (issued < target) begin
            run_cycle(1'b1, mode, bp_pct);
        end
    endtask

    // Bounded wait, leftovers show up in the final pending scan
    task automatic drain_results(input int unsigned bp_pct);
        int unsigned waited;
        waited = 0;
        while (pend_cnt != 0 && waited < DRAIN_LIMIT) begin
            run_cycle(1'b0, MODE_MIX, bp_pct);
            waited++;
        end
    endtask

    // Three cycles low, then the scoreboard forgets all work in flight
    task automatic apply_reset();
        int i;
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_taken   = 1'b0;
        cdb_ready_i = 1'b1;
        repeat (3) @(negedge clk_i);
        for (i = 0; i < 32; i++) begin
            pending[i] = 1'b0;
        end
        alu_order.delete();
        pend_cnt = 0;
        arst_n_i = 1'b1;
        #1;
        check_equal(32'(cdb_valid_o), 32'd0, "cdb_valid_o after reset");
        check_equal(32'(req_ready_o), 32'd1, "req_ready_o after reset");
    endtask

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------

    initial begin
        int i;
        clk_i       = 1'b0;
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        cdb_ready_i = 1'b0;
        rng_state   = 32'h6b65_4e32;
        issued      = 0;
        errors      = 0;
        fails       = 0;
        pend_cnt    = 0;
        next_tag    = '0;
        req_taken   = 1'b0;

        apply_reset();

        // ALU only, then MUL only, no stalls
        run_ops(N_ALU, MODE_ALU, 0);
        drain_results(0);
        run_ops(N_MUL, MODE_MUL, 0);
        drain_results(0);

        // Multiplier competing with ALU traffic
        run_ops(N_MIX, MODE_MIX, 0);
        drain_results(0);

        // Bus stalled about 30% of cycles
        run_ops(N_BP, MODE_MIX, 30);
        drain_results(30);

        // Reset with work still in flight
        run_ops(N_PRE_RST, MODE_MIX, 30);
        @(negedge clk_i);
        apply_reset();
        run_ops(N_POST_RST, MODE_MIX, 30);
        drain_results(30);

        // Bus must stay quiet once drained
        repeat (8) run_cycle(1'b0, MODE_MIX, 0);
        for (i = 0; i < 32; i++) begin
            if (pending[i]) begin
                fails++;
                $display("Tag %0d is still pending after the pipeline drained", i);
            end
        end
        if (alu_order.size() != 0) begin
            fails++;
            $display("%0d ALU results never arrived", alu_order.size());
        end

        $display("Errors: %0d mismatches, %0d other failures, %0d operations issued",
                 errors, fails, issued);
        if (errors == 0 && fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Run limit
    initial begin
        wait (cycles >= MAX_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Errors: %0d mismatches, %0d other failures, %0d operations issued",
                 errors, fails + 1, issued);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== src/wb_cdb_top.sv ====
// ------------------------------------------------
// Write-back CDB top level
// ------------------------------------------------

`timescale 1ns/1ps

module wb_cdb_top (
    input  logic              clk_i,
    input  logic              arst_n_i,

    // Operation requests
    input  logic              req_valid_i,
    input  cdb_pkg::op_req_t  req_i,
    output logic              req_ready_o,

    // Common data bus
    output logic              cdb_valid_o,
    output cdb_pkg::cdb_pkt_t cdb_o,
    input  logic              cdb_ready_i
);
    import cdb_pkg::*;

    // ------------------------------------------------
    // Interconnect
    // ------------------------------------------------

    // Dispatcher to units
    logic     alu_valid;
    logic     alu_ready;
    logic     mul_valid;
    logic     mul_ready;

    // Units to arbiter
    logic     alu_res_valid;
    logic     alu_res_ready;
    cdb_pkt_t alu_res;
    logic     mul_res_valid;
    logic     mul_res_ready;
    cdb_pkt_t mul_res;

    // ------------------------------------------------
    // Dispatch
    // ------------------------------------------------

    op_dispatcher op_dispatcher_inst (
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .alu_valid_o (alu_valid),
        .alu_ready_i (alu_ready),
        .mul_valid_o (mul_valid),
        .mul_ready_i (mul_ready)
    );

    // ------------------------------------------------
    // Functional units
    // ------------------------------------------------

    // Request struct shared by both units
    alu_unit alu_unit_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (alu_valid),
        .req_i    (req_i),
        .ready_o  (alu_ready),
        .valid_o  (alu_res_valid),
        .res_o    (alu_res),
        .ready_i  (alu_res_ready)
    );

    iter_mul_unit iter_mul_unit_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (mul_valid),
        .req_i    (req_i),
        .ready_o  (mul_ready),
        .valid_o  (mul_res_valid),
        .res_o    (mul_res),
        .ready_i  (mul_res_ready)
    );

    // ------------------------------------------------
    // CDB arbitration
    // ------------------------------------------------

    // Multiplier on the high priority side
    prio_2way_arbiter #(
        .DATA_T (cdb_pkt_t)
    ) prio_2way_arbiter_inst (
        .high_prio_valid_i (mul_res_valid),
        .low_prio_valid_i  (alu_res_valid),
        .ready_i           (cdb_ready_i),
        .valid_o           (cdb_valid_o),
        .high_prio_ready_o (mul_res_ready),
        .low_prio_ready_o  (alu_res_ready),
        .high_prio_data_i  (mul_res),
        .low_prio_data_i   (alu_res),
        .data_o            (cdb_o)
    );

endmodule

// ==== src/prio_2way_arbiter.sv ====
// ------------------------------------------------
// Fixed-priority two-way arbiter
// ------------------------------------------------

`timescale 1ns/1ps

module prio_2way_arbiter #(
    parameter type DATA_T = logic
) (
    // Handshake
    input  logic  high_prio_valid_i,
    input  logic  low_prio_valid_i,
    input  logic  ready_i,
    output logic  valid_o,
    output logic  high_prio_ready_o,
    output logic  low_prio_ready_o,

    // Payload
    input  DATA_T high_prio_data_i,
    input  DATA_T low_prio_data_i,
    output DATA_T data_o
);

    // ------------------------------------------------
    // Grant logic
    // ------------------------------------------------

    // Low priority side picked for the mux
    logic sel_low;

    always_comb begin
        // Downstream stalled, nobody moves
        high_prio_ready_o = 1'b0;
        low_prio_ready_o  = 1'b0;
        sel_low           = 1'b0;

        if (ready_i) begin
            if (high_prio_valid_i) begin
                // High side always wins
                high_prio_ready_o = 1'b1;
            end else if (low_prio_valid_i) begin
                low_prio_ready_o = 1'b1;
                sel_low          = 1'b1;
            end else begin
                // Idle, both open
                high_prio_ready_o = 1'b1;
                low_prio_ready_o  = 1'b1;
            end
        end

        // Never grant both sides of a live request
        assert (!(high_prio_ready_o && low_prio_ready_o
                  && (high_prio_valid_i || low_prio_valid_i)));
    end

    // ------------------------------------------------
    // Output
    // ------------------------------------------------

    assign valid_o = high_prio_valid_i | low_prio_valid_i;

    // Follows high side unless low is selected
    assign data_o = sel_low ? low_prio_data_i : high_prio_data_i;

endmodule

// ==== src/iter_mul_unit.sv ====
// ------------------------------------------------
// Iterative shift-and-add multiplier
// ------------------------------------------------

`timescale 1ns/1ps

module iter_mul_unit (
    input  logic              clk_i,
    input  logic              arst_n_i,

    // Request side
    input  logic              valid_i,
    input  cdb_pkg::op_req_t  req_i,
    output logic              ready_o,

    // Result side
    output logic              valid_o,
    output cdb_pkg::cdb_pkt_t res_o,
    input  logic              ready_i
);
    import cdb_pkg::*;

    // Step counter width
    localparam int unsigned CNT_W = $clog2(MUL_STEPS);

    // ------------------------------------------------
    // FSM and registers
    // ------------------------------------------------

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } mul_state_e;

    mul_state_e state_q;
    logic [CNT_W-1:0] cnt_q;

    // Operands shift, product accumulates
    xlen_t mcand_q;
    xlen_t mplier_q;
    xlen_t prod_q;
    tag_t  tag_q;

    // Last iteration reached
    logic last_step;

    assign last_step = (cnt_q == CNT_W'(MUL_STEPS - 1));

    // ------------------------------------------------
    // Control
    // ------------------------------------------------

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (valid_i) begin
                        state_q <= BUSY;
                        cnt_q   <= '0;
                    end
                end
                BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_step) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    // Hold until taken
                    if (ready_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // ------------------------------------------------
    // Datapath
    // ------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && valid_i) begin
            mcand_q  <= req_i.rs1;
            mplier_q <= req_i.rs2;
            prod_q   <= '0;
            tag_q    <= req_i.tag;
        end else if (state_q == BUSY) begin
            // Add shifted multiplicand for each set bit
            if (mplier_q[0]) begin
                prod_q <= prod_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign ready_o   = (state_q == IDLE);
    assign valid_o   = (state_q == DONE);
    assign res_o.tag   = tag_q;
    assign res_o.value = prod_q;

    // ------------------------------------------------
    // Checks
    // ------------------------------------------------

    // Accepted request finishes after exactly MUL_STEPS busy cycles
    a_mul_latency: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        valid_i && ready_o |=> (state_q == BUSY) [*MUL_STEPS] ##1 (state_q == DONE)
    );

    // Counter wraps back to zero when the busy phase ends
    a_cnt_range: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        state_q != BUSY |-> cnt_q == '0
    );

endmodule

// ==== src/alu_unit.sv ====
// ------------------------------------------------
// Single-cycle ALU
// ------------------------------------------------

`timescale 1ns/1ps

module alu_unit (
    input  logic              clk_i,
    input  logic              arst_n_i,

    // Request side
    input  logic              valid_i,
    input  cdb_pkg::op_req_t  req_i,
    output logic              ready_o,

    // Result side
    output logic              valid_o,
    output cdb_pkg::cdb_pkt_t res_o,
    input  logic              ready_i
);
    import cdb_pkg::*;

    // ------------------------------------------------
    // Internal signals
    // ------------------------------------------------

    // Shift amount, low bits of rs2
    logic [4:0] shamt;

    // Combinational result
    xlen_t      alu_res;

    // Output register
    logic       valid_q;
    cdb_pkt_t   res_q;

    assign shamt = req_i.rs2[4:0];

    // ------------------------------------------------
    // Datapath
    // ------------------------------------------------

    always_comb begin
        case (req_i.op)
            ADD:     alu_res = req_i.rs1 + req_i.rs2;
            SUB:     alu_res = req_i.rs1 - req_i.rs2;
            AND:     alu_res = req_i.rs1 & req_i.rs2;
            OR:      alu_res = req_i.rs1 | req_i.rs2;
            XOR:     alu_res = req_i.rs1 ^ req_i.rs2;
            SLL:     alu_res = req_i.rs1 << shamt;
            SRL:     alu_res = req_i.rs1 >> shamt;
            // MUL never routed here
            default: alu_res = '0;
        endcase
    end

    // ------------------------------------------------
    // Output register
    // ------------------------------------------------

    // Free when empty or draining this cycle
    assign ready_o = !valid_q || ready_i;

    // Valid flag
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (valid_i && ready_o) begin
            valid_q <= 1'b1;
        end else if (ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // Tagged payload, held while stalled
    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            res_q.tag   <= req_i.tag;
            res_q.value <= alu_res;
        end
    end

    assign valid_o = valid_q;
    assign res_o   = res_q;

    // ------------------------------------------------
    // Checks
    // ------------------------------------------------

    // Pending result stays put until the bus takes it
    a_hold_result: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(res_o)
    );

endmodule

// ==== src/op_dispatcher.sv ====
// ------------------------------------------------
// Operation dispatcher
// ------------------------------------------------

`timescale 1ns/1ps

module op_dispatcher (
    // Request from producer
    input  logic             req_valid_i,
    input  cdb_pkg::op_req_t req_i,
    output logic             req_ready_o,

    // ALU side
    output logic             alu_valid_o,
    input  logic             alu_ready_i,

    // Multiplier side
    output logic             mul_valid_o,
    input  logic             mul_ready_i
);
    import cdb_pkg::*;

    // ------------------------------------------------
    // Operation class
    // ------------------------------------------------

    // Only MUL goes to the multiplier
    logic is_mul;

    assign is_mul = (req_i.op == MUL);

    // ------------------------------------------------
    // Valid steering
    // ------------------------------------------------

    always_comb begin
        // Nothing forwarded by default
        alu_valid_o = 1'b0;
        mul_valid_o = 1'b0;

        if (req_valid_i) begin
            if (is_mul) begin
                mul_valid_o = 1'b1;
            end else begin
                alu_valid_o = 1'b1;
            end
        end
    end

    // ------------------------------------------------
    // Ready merge
    // ------------------------------------------------

    // Ready of the unit the request would go to
    assign req_ready_o = is_mul ? mul_ready_i : alu_ready_i;

endmodule

// ==== src/cdb_pkg.sv ====
// ------------------------------------------------
// Write-back stage shared types
// ------------------------------------------------

package cdb_pkg;

    // ------------------------------------------------
    // Widths
    // ------------------------------------------------

    // Operand and result width
    localparam int unsigned XLEN = 32;

    // Multiplier iterations, one per multiplier bit
    localparam int unsigned MUL_STEPS = XLEN;

    // Operand and result values
    typedef logic [XLEN-1:0] xlen_t;

    // Destination register tag
    typedef logic [4:0] tag_t;

    // ------------------------------------------------
    // Operations
    // ------------------------------------------------

    // ALU class first, MUL goes to the multiplier
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        MUL = 3'd7
    } fu_op_e;

    // ------------------------------------------------
    // Packets
    // ------------------------------------------------

    // Operation request, 72 bits
    typedef struct packed {
        fu_op_e op;
        xlen_t  rs1;
        xlen_t  rs2;
        tag_t   tag;
    } op_req_t;

    // Result on the common data bus, 37 bits
    typedef struct packed {
        tag_t  tag;
        xlen_t value;
    } cdb_pkt_t;

endpackage
